/* Bender.yml */
package:
  name: esaxi

sources:
  - logic/esaxi_pkg.sv
  - logic/esaxi_write_channel.sv
  - logic/esaxi_read_channel.sv
  - logic/esaxi_packet_codec.sv
  - logic/esaxi.sv
  - target: simulation
    files:
      - tb/tb_clkgen.sv
      - tb/tb_esaxi.sv

/* list.f */
logic/esaxi_pkg.sv
logic/esaxi_write_channel.sv
logic/esaxi_read_channel.sv
logic/esaxi_packet_codec.sv
logic/esaxi.sv
tb/tb_clkgen.sv
tb/tb_esaxi.sv

/* logic/esaxi.sv */
`timescale 1ns/10ps
`default_nettype none

module esaxi
   import esaxi_pkg::*;
#(
   parameter logic [11:0] id  = 12'h810,    // mesh node id
   parameter int          idw = 12          // axi id width
)
(
   input  wire              s_axi_aclk,
   input  wire              s_axi_aresetn,
   // write address
   input  wire [idw-1:0]    s_axi_awid,
   input  wire [aw-1:0]     s_axi_awaddr,
   input  wire [7:0]        s_axi_awlen,
   input  wire [2:0]        s_axi_awsize,
   input  wire [1:0]        s_axi_awburst,
   input  wire              s_axi_awvalid,
   output logic             s_axi_awready,
   // write data
   input  wire [dw-1:0]     s_axi_wdata,
   input  wire [dw/8-1:0]   s_axi_wstrb,
   input  wire              s_axi_wlast,
   input  wire              s_axi_wvalid,
   output logic             s_axi_wready,
   // write response
   output logic [idw-1:0]   s_axi_bid,
   output logic [1:0]       s_axi_bresp,
   output logic             s_axi_bvalid,
   input  wire              s_axi_bready,
   // read address
   input  wire [idw-1:0]    s_axi_arid,
   input  wire [aw-1:0]     s_axi_araddr,
   input  wire [7:0]        s_axi_arlen,
   input  wire [2:0]        s_axi_arsize,
   input  wire [1:0]        s_axi_arburst,
   input  wire              s_axi_arvalid,
   output logic             s_axi_arready,
   // read data
   output logic [idw-1:0]   s_axi_rid,
   output logic [dw-1:0]    s_axi_rdata,
   output logic [1:0]       s_axi_rresp,
   output logic             s_axi_rlast,
   output logic             s_axi_rvalid,
   input  wire              s_axi_rready,
   // mesh side
   output logic             txwr_access,
   output logic [pw-1:0]    txwr_packet,
   input  wire              txwr_wait,
   output logic             txrd_access,
   output logic [pw-1:0]    txrd_packet,
   input  wire              rxrr_access,
   input  wire [pw-1:0]     rxrr_packet
);

   logic [aw-1:0]      wr_dstaddr;
   logic [dw-1:0]      wr_data;
   logic [dmode_w-1:0] wr_datamode;
   logic [aw-1:0]      rd_dstaddr;
   logic [dmode_w-1:0] rd_datamode;
   logic [dw-1:0]      rsp_data;            // unpacked response word

   // ####################################################################
   // channels and codec
   // ####################################################################
   esaxi_write_channel #(.idw(idw)) u_write_channel (
      .s_axi_aclk (s_axi_aclk),     .s_axi_aresetn (s_axi_aresetn),
      .awid       (s_axi_awid),     .awaddr        (s_axi_awaddr),
      .awlen      (s_axi_awlen),    .awsize        (s_axi_awsize),
      .awburst    (s_axi_awburst),  .awvalid       (s_axi_awvalid),
      .awready    (s_axi_awready),  .wdata         (s_axi_wdata),
      .wstrb      (s_axi_wstrb),    .wlast         (s_axi_wlast),
      .wvalid     (s_axi_wvalid),   .wready        (s_axi_wready),
      .bid        (s_axi_bid),      .bresp         (s_axi_bresp),
      .bvalid     (s_axi_bvalid),   .bready        (s_axi_bready),
      .txwr_wait  (txwr_wait),      .wr_req        (txwr_access),  // request level is the access
      .wr_dstaddr (wr_dstaddr),     .wr_data       (wr_data),
      .wr_datamode(wr_datamode)
   );

   esaxi_read_channel #(.idw(idw)) u_read_channel (
      .s_axi_aclk (s_axi_aclk),     .s_axi_aresetn (s_axi_aresetn),
      .arid       (s_axi_arid),     .araddr        (s_axi_araddr),
      .arlen      (s_axi_arlen),    .arsize        (s_axi_arsize),
      .arburst    (s_axi_arburst),  .arvalid       (s_axi_arvalid),
      .arready    (s_axi_arready),  .rid           (s_axi_rid),
      .rdata      (s_axi_rdata),    .rresp         (s_axi_rresp),
      .rlast      (s_axi_rlast),    .rvalid        (s_axi_rvalid),
      .rready     (s_axi_rready),   .rxrr_access   (rxrr_access),
      .rsp_data   (rsp_data),       .rd_req        (txrd_access),
      .rd_dstaddr (rd_dstaddr),     .rd_datamode   (rd_datamode)
   );

   esaxi_packet_codec #(.id(id)) u_packet_codec (
      .wr_dstaddr (wr_dstaddr),     .wr_data       (wr_data),
      .wr_datamode(wr_datamode),    .rd_dstaddr    (rd_dstaddr),
      .rd_datamode(rd_datamode),    .rxrr_packet   (rxrr_packet),
      .txwr_packet(txwr_packet),    .txrd_packet   (txrd_packet),
      .rsp_data   (rsp_data)
   );

endmodule

`default_nettype wire

/* logic/esaxi_packet_codec.sv */
`timescale 1ns/10ps
`default_nettype none

module esaxi_packet_codec
   import esaxi_pkg::*;
#(
   parameter logic [11:0] id = 12'h810
)
(
   input  wire [aw-1:0]      wr_dstaddr,
   input  wire [dw-1:0]      wr_data,
   input  wire [dmode_w-1:0] wr_datamode,
   input  wire [aw-1:0]      rd_dstaddr,
   input  wire [dmode_w-1:0] rd_datamode,
   input  wire [pw-1:0]      rxrr_packet,
   output logic [pw-1:0]     txwr_packet,
   output logic [pw-1:0]     txrd_packet,
   output logic [dw-1:0]     rsp_data
);

   logic [aw-1:0] return_addr;              // where the remote node answers

   assign return_addr = {id, egroup_rr, 16'h0000};

   // write packet, no return address
   always_comb
   begin
      txwr_packet                             = '0;
      txwr_packet[pkt_write_bit]              = 1'b1;
      txwr_packet[pkt_dmode_lsb +: dmode_w]   = wr_datamode;
      txwr_packet[pkt_ctrl_lsb +: ctrl_w]     = '0;
      txwr_packet[pkt_dst_lsb +: aw]          = wr_dstaddr;
      txwr_packet[pkt_data_lsb +: dw]         = wr_data;
   end

   // read request, data field unused
   always_comb
   begin
      txrd_packet                             = '0;
      txrd_packet[pkt_write_bit]              = 1'b0;
      txrd_packet[pkt_dmode_lsb +: dmode_w]   = rd_datamode;
      txrd_packet[pkt_ctrl_lsb +: ctrl_w]     = '0;
      txrd_packet[pkt_dst_lsb +: aw]          = rd_dstaddr;
      txrd_packet[pkt_src_lsb +: aw]          = return_addr;
   end

   assign rsp_data = rxrr_packet[pkt_data_lsb +: dw];   // only the data is needed

endmodule

`default_nettype wire

/* logic/esaxi_pkg.sv */
`default_nettype none

package esaxi_pkg;

   // ####################################################################
   // widths
   // ####################################################################
   localparam int aw      = 32;             // axi and mesh address
   localparam int dw      = 32;             // data word
   localparam int pw      = 104;            // mesh packet
   localparam int dmode_w = 2;              // datamode field
   localparam int ctrl_w  = 5;              // ctrlmode field

   // axi codes
   localparam logic [1:0] burst_incr = 2'b01;    // fixed and wrap are treated alike
   localparam logic [2:0] size_byte  = 3'd0;
   localparam logic [2:0] size_half  = 3'd1;
   localparam logic [2:0] size_word  = 3'd2;
   localparam logic [1:0] resp_okay  = 2'b00;

   // read response group, sits under the node id in the return address
   localparam logic [3:0] egroup_rr = 4'he;

   // ####################################################################
   // packet field positions
   // ####################################################################
   localparam int pkt_write_bit = 0;        // 1 = write, 0 = read request
   localparam int pkt_dmode_lsb = 1;        // bits 2:1
   localparam int pkt_ctrl_lsb  = 3;        // bits 7:3, kept zero
   localparam int pkt_dst_lsb   = 8;        // bits 39:8
   localparam int pkt_data_lsb  = 40;       // bits 71:40
   localparam int pkt_src_lsb   = 72;       // bits 103:72

   // one data word, whole or by byte lane
   typedef union packed {
      logic [dw-1:0]   word;
      logic [3:0][7:0] bytes;               // lane 0 is the lowest address
   } data_word_u;

endpackage

`default_nettype wire

/* logic/esaxi_read_channel.sv */
`timescale 1ns/10ps
`default_nettype none

module esaxi_read_channel
   import esaxi_pkg::*;
#(
   parameter int idw = 12
)
(
   input  wire                s_axi_aclk,
   input  wire                s_axi_aresetn,
   input  wire [idw-1:0]      arid,
   input  wire [aw-1:0]       araddr,
   input  wire [7:0]          arlen,
   input  wire [2:0]          arsize,
   input  wire [1:0]          arburst,
   input  wire                arvalid,
   output logic               arready,
   output logic [idw-1:0]     rid,
   output logic [dw-1:0]      rdata,
   output logic [1:0]         rresp,
   output logic               rlast,
   output logic               rvalid,
   input  wire                rready,
   input  wire                rxrr_access,
   input  wire [dw-1:0]       rsp_data,
   output logic               rd_req,
   output logic [aw-1:0]      rd_dstaddr,
   output logic [dmode_w-1:0] rd_datamode
);

   data_word_u    rsp;                      // byte view of the response
   logic          read_active;              // ar taken, last r not yet
   logic          ractive_q;                // for the rising edge
   logic          rnext;                    // non-last beat done, ask again
   logic [7:0]    arlen_q;                  // beats still to go
   logic [aw-1:0] araddr_q;
   logic [2:0]    arsize_q;
   logic [1:0]    arburst_q;
   logic          r_beat;
   logic          last_r_beat;

   assign rsp         = data_word_u'(rsp_data);
   assign r_beat      = rvalid & rready;
   assign last_r_beat = r_beat & rlast;
   assign rresp       = resp_okay;

   // ####################################################################
   // address channel and beat count
   // ####################################################################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         arready     <= 1'b0;
         read_active <= 1'b0;
         arlen_q     <= 8'd0;
         rlast       <= 1'b0;
      end
      else
      begin
         if (!arready && !read_active)
            arready <= 1'b1;
         else if (arvalid)
            arready <= 1'b0;
         if (arready && arvalid)
            read_active <= 1'b1;
         else if (last_r_beat)
            read_active <= 1'b0;
         if (arready && arvalid)
         begin
            arlen_q <= arlen;
            rlast   <= (arlen == 8'd0);     // single beat read
         end
         else if (r_beat)
         begin
            arlen_q <= arlen_q - 8'd1;
            if (arlen_q == 8'd1)
               rlast <= 1'b1;
         end
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (arready && arvalid)
      begin
         araddr_q  <= araddr;
         arsize_q  <= arsize;
         arburst_q <= arburst;
         rid       <= arid;
      end
      else if (r_beat && arburst_q == burst_incr)
      begin
         araddr_q[aw-1:2] <= araddr_q[aw-1:2] + 1'b1;
         araddr_q[1:0]    <= 2'b00;
      end
   end

   // ####################################################################
   // request issue, one per beat
   // ####################################################################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         ractive_q <= 1'b0;
         rnext     <= 1'b0;
         rd_req    <= 1'b0;
         rvalid    <= 1'b0;
      end
      else
      begin
         ractive_q <= read_active;
         rnext     <= r_beat & !rlast;
         rd_req    <= (read_active & !ractive_q) | rnext;
         if (rxrr_access)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      rd_dstaddr  <= araddr_q;
      rd_datamode <= arsize_q[1:0];
      if (rxrr_access)
      begin
         case (arsize_q)
            size_byte : rdata <= {4{rsp.bytes[0]}};
            size_half : rdata <= {2{rsp.bytes[1:0]}};
            default   : rdata <= rsp.word;
         endcase
      end
   end

   // responses only for the one read in flight
   rsp_only_when_active : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      rxrr_access |-> read_active);

endmodule

`default_nettype wire

/* logic/esaxi_write_channel.sv */
`timescale 1ns/10ps
`default_nettype none

module esaxi_write_channel
   import esaxi_pkg::*;
#(
   parameter int idw = 12
)
(
   input  wire                s_axi_aclk,
   input  wire                s_axi_aresetn,
   input  wire [idw-1:0]      awid,
   input  wire [aw-1:0]       awaddr,
   input  wire [7:0]          awlen,        // only checked against wlast
   input  wire [2:0]          awsize,
   input  wire [1:0]          awburst,
   input  wire                awvalid,
   output logic               awready,
   input  wire [dw-1:0]       wdata,
   input  wire [dw/8-1:0]     wstrb,
   input  wire                wlast,
   input  wire                wvalid,
   output logic               wready,
   output logic [idw-1:0]     bid,
   output logic [1:0]         bresp,
   output logic               bvalid,
   input  wire                bready,
   input  wire                txwr_wait,
   output logic               wr_req,
   output logic [aw-1:0]      wr_dstaddr,
   output logic [dw-1:0]      wr_data,
   output logic [dmode_w-1:0] wr_datamode
);

   data_word_u         wd;                  // byte view of wdata
   logic               write_active;        // aw taken, last beat not yet
   logic [7:0]         beats_left;
   logic [aw-1:0]      awaddr_q;
   logic [2:0]         awsize_q;
   logic [1:0]         awburst_q;
   logic               beat;
   logic               last_beat;
   logic               pre_req;             // stage 1 valid
   logic [aw-1:0]      dst_s1;
   logic [dw-1:0]      data_s1;
   logic [dmode_w-1:0] dmode_s1;

   assign wd        = data_word_u'(wdata);
   assign beat      = wready & wvalid;
   assign last_beat = beat & wlast;
   assign bresp     = resp_okay;            // no error path

   // ####################################################################
   // address and response handshakes
   // ####################################################################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         awready      <= 1'b1;
         write_active <= 1'b0;
         beats_left   <= 8'd0;
         wready       <= 1'b0;
         bvalid       <= 1'b0;
      end
      else
      begin
         if (!awready && !write_active && !bvalid)
            awready <= 1'b1;                // burst and b both done
         else if (awvalid)
            awready <= 1'b0;
         if (awready && awvalid)
         begin
            write_active <= 1'b1;
            beats_left   <= awlen;
         end
         else if (beat)
         begin
            write_active <= !wlast;
            beats_left   <= beats_left - 8'd1;
         end
         if (last_beat)
            wready <= 1'b0;                 // closes the burst
         else if (write_active)
            wready <= !txwr_wait;           // one cycle behind the wait level
         if (last_beat)
            bvalid <= 1'b1;
         else if (bready && bvalid)
            bvalid <= 1'b0;
      end
   end

   // burst capture, word address steps on incr only
   always_ff @(posedge s_axi_aclk)
   begin
      if (awready && awvalid)
      begin
         bid       <= awid;
         awaddr_q  <= awaddr;
         awsize_q  <= awsize;
         awburst_q <= awburst;
      end
      else if (beat && awburst_q == burst_incr)
      begin
         awaddr_q[aw-1:2] <= awaddr_q[aw-1:2] + 1'b1;
         awaddr_q[1:0]    <= 2'b00;
      end
   end

   // ####################################################################
   // request pipeline, two stages behind the beat
   // ####################################################################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         pre_req <= 1'b0;
         wr_req  <= 1'b0;
      end
      else
      begin
         pre_req <= beat;
         wr_req  <= pre_req;
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      dmode_s1         <= awsize_q[1:0];
      dst_s1[aw-1:2]   <= awaddr_q[aw-1:2];
      // lowest strobe picks the lane, word writes go through as is
      if (wstrb[0] || awsize_q == size_word)
      begin
         data_s1     <= wd.word;
         dst_s1[1:0] <= 2'd0;
      end
      else if (wstrb[1])
      begin
         data_s1     <= {8'h00, wd.bytes[3:1]};
         dst_s1[1:0] <= 2'd1;
      end
      else if (wstrb[2])
      begin
         data_s1     <= {16'h0000, wd.bytes[3:2]};
         dst_s1[1:0] <= 2'd2;
      end
      else
      begin
         data_s1     <= {24'h000000, wd.bytes[3]};  // lane 3 or no strobe
         dst_s1[1:0] <= 2'd3;
      end
      wr_dstaddr  <= dst_s1;
      wr_data     <= data_s1;
      wr_datamode <= dmode_s1;
   end

   // b only after the burst has closed
   bvalid_after_burst : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      $rose(bvalid) |-> !write_active);

   // master's wlast must line up with awlen
   wlast_on_final_beat : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      beat |-> (wlast == (beats_left == 8'd0)));

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen
#(
   parameter real period       = 40.0,   // ns
   parameter int  reset_cycles = 10
)
(
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #(period / 2.0) clk = ~clk;
   end

   // active low, released on a rising edge
   initial
   begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

/* tb/tb_esaxi.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_esaxi
   import esaxi_pkg::*;
;

   localparam logic [11:0] node_id = 12'h810;
   // beats at most plus one address phase, per burst
   localparam int planned_transfers = 2 + 6*2 + 6*10 + 3*10 + 4*10 + 6*2;
   localparam int cycle_limit       = 200 * planned_transfers + 1000;

   logic s_axi_aclk, s_axi_aresetn;
   logic [11:0] s_axi_awid, s_axi_bid, s_axi_arid, s_axi_rid;
   logic [31:0] s_axi_awaddr, s_axi_wdata, s_axi_araddr, s_axi_rdata;
   logic [7:0] s_axi_awlen, s_axi_arlen;
   logic [2:0] s_axi_awsize, s_axi_arsize;
   logic [1:0] s_axi_awburst, s_axi_arburst, s_axi_bresp, s_axi_rresp;
   logic [3:0] s_axi_wstrb;
   logic s_axi_awvalid, s_axi_awready, s_axi_wlast, s_axi_wvalid, s_axi_wready;
   logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
   logic s_axi_rlast, s_axi_rvalid, s_axi_rready;
   logic txwr_access, txwr_wait, txrd_access, rxrr_access;
   logic [103:0] txwr_packet, txrd_packet, rxrr_packet;

   integer seed = 32'h604c_0dcf;
   int errors = 0;
   int checks = 0;
   int cycles = 0;
   int wr_beats = 0;                     // accepted w beats
   int wr_pkts = 0;                      // txwr packets seen
   logic wait_test = 1'b0;               // random txwr_wait on
   logic wait_q = 1'b0;                  // txwr_wait one cycle back
   logic [103:0] exp_txwr[$];
   logic [103:0] exp_txrd[$];
   logic [44:0]  exp_r[$];               // {rlast, rid, rdata}

   tb_clkgen u_clkgen (.clk(s_axi_aclk), .rst_n(s_axi_aresetn));

   esaxi #(.id(node_id), .idw(12)) u_dut (.*);

   // ####################################################################
   // reference model
   // ####################################################################
   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};   // remote memory
   endfunction

   function automatic logic [103:0] write_packet_of(input logic [31:0] addr, input int beat,
      input logic [1:0] burst, input logic [2:0] size, input logic [31:0] data,
      input logic [3:0] strb);
      logic [103:0] pkt;
      logic [29:0]  word;
      int           lane;
      word = (burst == burst_incr) ? addr[31:2] + 30'(beat) : addr[31:2];
      lane = 0;
      if (size != size_word)
         for (int i = 3; i >= 0; i--)
            if (strb[i])
               lane = i;                 // lowest set lane wins
      pkt        = '0;
      pkt[0]     = 1'b1;
      pkt[2:1]   = size[1:0];
      pkt[39:8]  = {word, 2'(lane)};
      pkt[71:40] = data >> (8 * lane);   // zero fill from the top
      return pkt;
   endfunction

   function automatic logic [31:0] read_beat_addr(input logic [31:0] addr, input int beat,
      input logic [1:0] burst);
      if (beat == 0 || burst != burst_incr)
         return addr;                    // first beat keeps the low bits
      return {addr[31:2] + 30'(beat), 2'b00};
   endfunction

   function automatic logic [103:0] read_packet_of(input logic [31:0] addr,
      input logic [2:0] size);
      logic [103:0] pkt;
      pkt         = '0;
      pkt[2:1]    = size[1:0];
      pkt[39:8]   = addr;
      pkt[103:72] = {node_id, egroup_rr, 16'h0000};   // return address
      return pkt;
   endfunction

   function automatic logic [31:0] replicated_rdata(input logic [31:0] w, input logic [2:0] size);
      case (size)
         3'd0    : return {4{w[7:0]}};
         3'd1    : return {2{w[15:0]}};
         default : return w;
      endcase
   endfunction

   task automatic check(input string name, input logic [103:0] got, input logic [103:0] want);
      checks++;
      if (got !== want)
      begin
         errors++;
         $display("[FAIL] %s: got %0h, expected %0h", name, got, want);
      end
   endtask

   task automatic note_error(input string msg);
      errors++;
      $display("error: %s", msg);
   endtask

   // ####################################################################
   // bus tasks
   // ####################################################################
   task automatic write_burst(input logic [11:0] wid, input logic [31:0] addr, input int len,
      input logic [2:0] size, input logic [1:0] burst, input logic [3:0] strb);
      logic [31:0] data;
      s_axi_awid    <= wid;
      s_axi_awaddr  <= addr;
      s_axi_awlen   <= len[7:0];
      s_axi_awsize  <= size;
      s_axi_awburst <= burst;
      s_axi_awvalid <= 1'b1;
      do
         @(posedge s_axi_aclk);
      while (s_axi_awready !== 1'b1);
      s_axi_awvalid <= 1'b0;
      for (int k = 0; k <= len; k++)
      begin
         data = $random(seed);
         exp_txwr.push_back(write_packet_of(addr, k, burst, size, data, strb));
         s_axi_wdata  <= data;
         s_axi_wstrb  <= strb;
         s_axi_wlast  <= (k == len);
         s_axi_wvalid <= 1'b1;
         do
            @(posedge s_axi_aclk);
         while (s_axi_wready !== 1'b1);
      end
      s_axi_wvalid <= 1'b0;
      s_axi_wlast  <= 1'b0;
      do
         @(posedge s_axi_aclk);
      while (s_axi_bvalid !== 1'b1);    // bready stays high
      check("s_axi_bid", s_axi_bid, wid);
      check("s_axi_bresp", s_axi_bresp, resp_okay);
   endtask

   task automatic read_burst(input logic [11:0] rid, input logic [31:0] addr, input int len,
      input logic [2:0] size, input logic [1:0] burst);
      logic [31:0] a;
      int          beats;
      for (int k = 0; k <= len; k++)
      begin
         a = read_beat_addr(addr, k, burst);
         exp_txrd.push_back(read_packet_of(a, size));
         exp_r.push_back({k == len, rid, replicated_rdata(mem_word(a), size)});
      end
      s_axi_arid    <= rid;
      s_axi_araddr  <= addr;
      s_axi_arlen   <= len[7:0];
      s_axi_arsize  <= size;
      s_axi_arburst <= burst;
      s_axi_arvalid <= 1'b1;
      do
         @(posedge s_axi_aclk);
      while (s_axi_arready !== 1'b1);
      s_axi_arvalid <= 1'b0;
      beats = 0;
      while (beats <= len)
      begin
         @(posedge s_axi_aclk);
         if (s_axi_rvalid === 1'b1 && s_axi_rready === 1'b1)
            beats++;
         s_axi_rready <= ({$random(seed)} % 4) != 0;   // mostly ready
      end
      s_axi_rready <= 1'b0;
   endtask

   // ####################################################################
   // remote node, compare and watchdog
   // ####################################################################
   always
   begin : remote_node
      logic [31:0] dst;
      int          delay;
      @(posedge s_axi_aclk);
      if (txrd_access === 1'b1)
      begin
         dst   = txrd_packet[39:8];
         delay = 1 + ({$random(seed)} % 6);
         repeat (delay) @(posedge s_axi_aclk);
         rxrr_access <= 1'b1;
         rxrr_packet <= {32'h0, mem_word(dst), 40'h0};
         @(posedge s_axi_aclk);
         rxrr_access <= 1'b0;
      end
   end

   always @(posedge s_axi_aclk)
      txwr_wait <= wait_test ? (({$random(seed)} % 4) != 0) : 1'b0;   // mostly high

   always @(posedge s_axi_aclk)
   begin : compare
      logic [44:0] beat;
      if (s_axi_aresetn === 1'b1)
      begin
         if (txwr_access === 1'b1)
         begin
            wr_pkts++;
            if (exp_txwr.size() == 0)
               note_error("write packet on txwr with no write beat behind it");
            else
               check("txwr_packet", txwr_packet, exp_txwr.pop_front());
         end
         if (txrd_access === 1'b1)
         begin
            if (exp_txrd.size() == 0)
               note_error("read request on txrd that no read asked for");
            else
               check("txrd_packet", txrd_packet, exp_txrd.pop_front());
         end
         if (s_axi_rvalid === 1'b1 && s_axi_rready === 1'b1)
         begin
            if (exp_r.size() == 0)
               note_error("read data beat that no read asked for");
            else
            begin
               beat = exp_r.pop_front();
               check("s_axi_rdata", s_axi_rdata, beat[31:0]);
               check("s_axi_rid", s_axi_rid, beat[43:32]);
               check("s_axi_rlast", s_axi_rlast, beat[44]);
               check("s_axi_rresp", s_axi_rresp, resp_okay);
            end
         end
         if (s_axi_wvalid === 1'b1 && s_axi_wready === 1'b1)
         begin
            wr_beats++;
            if (wait_q)
               note_error("write beat accepted while txwr_wait was high");
         end
      end
      wait_q = txwr_wait;                 // wready lags the wait by a cycle
   end

   always @(posedge s_axi_aclk)
   begin
      cycles++;
      if (cycles >= cycle_limit)
      begin
         $display("timeout: no progress after %0d cycles, %0d errors so far", cycles, errors);
         $display(">>> FAIL");
         $finish;
      end
   end

   // ####################################################################
   // stimulus
   // ####################################################################
   initial
   begin
      s_axi_awid    = '0;
      s_axi_awaddr  = '0;
      s_axi_awlen   = '0;
      s_axi_awsize  = '0;
      s_axi_awburst = '0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wstrb   = '0;
      s_axi_wlast   = 1'b0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b1;
      s_axi_arid    = '0;
      s_axi_araddr  = '0;
      s_axi_arlen   = '0;
      s_axi_arsize  = '0;
      s_axi_arburst = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      txwr_wait     = 1'b0;
      rxrr_access   = 1'b0;
      rxrr_packet   = '0;
      wait (s_axi_aresetn === 1'b1);
      @(posedge s_axi_aclk);
      write_burst($random(seed), $random(seed), 0, size_word, burst_incr, 4'hf);
      // narrow writes, lowest strobe above lane 0
      write_burst($random(seed), $random(seed), 0, size_byte, burst_incr, 4'b0010);
      write_burst($random(seed), $random(seed), 0, size_byte, burst_incr, 4'b0100);
      write_burst($random(seed), $random(seed), 0, size_byte, burst_incr, 4'b1000);
      write_burst($random(seed), $random(seed), 0, size_byte, burst_incr, 4'b1010);
      write_burst($random(seed), $random(seed), 0, size_half, burst_incr, 4'b1100);
      write_burst($random(seed), $random(seed), 0, size_half, burst_incr, 4'b0110);
      repeat (4) write_burst($random(seed), $random(seed), {$random(seed)} % 9, size_word,
                             burst_incr, 4'hf);
      repeat (2) write_burst($random(seed), $random(seed), {$random(seed)} % 9, size_word,
                             2'b00, 4'hf);           // fixed
      wait_test <= 1'b1;
      repeat (3) write_burst($random(seed), $random(seed), {$random(seed)} % 9, size_word,
                             burst_incr, 4'hf);
      wait_test <= 1'b0;
      repeat (3) read_burst($random(seed), $random(seed), {$random(seed)} % 9, size_word,
                            burst_incr);
      read_burst($random(seed), $random(seed), {$random(seed)} % 9, size_word, 2'b00);
      repeat (2) read_burst($random(seed), $random(seed), 0, size_byte, burst_incr);
      repeat (2) read_burst($random(seed), $random(seed), 0, size_half, burst_incr);
      repeat (2) read_burst($random(seed), $random(seed), 0, size_word, burst_incr);
      repeat (20) @(posedge s_axi_aclk);   // drain the write pipeline
      check("txwr packet count", wr_pkts, wr_beats);
      if (exp_txwr.size() + exp_txrd.size() + exp_r.size() != 0)
         note_error("some expected packets or read beats never appeared");
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire
